//--- hw/vcache_pkg.sv
package vcache_pkg;

    // ==============================
    // cache geometry
    // ==============================
    localparam int WAY_NUM      = 4;
    localparam int WAY_WIDTH    = 2;
    localparam int INDEX_WIDTH  = 6;
    localparam int TAG_WIDTH    = 12;
    localparam int OFFSET_WIDTH = 6;
    localparam int TXNID_WIDTH  = 8;

    typedef logic [1:0] opcode_t;

    localparam opcode_t OP_READ  = 2'd0;
    localparam opcode_t OP_WRITE = 2'd1;

    // ==============================
    // request side
    // ==============================
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic [TXNID_WIDTH-1:0] txnid;
        opcode_t                opcode;
        cache_addr_t            addr;
    } tag_req_t;

    // ==============================
    // tag and dirty arrays
    // ==============================
    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        tag_entry_t [WAY_NUM-1:0] way;
    } tag_row_t;

    typedef logic [WAY_NUM-1:0] dirty_row_t;    // one bit per way

    // tag to install through the fill buffer
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic [TAG_WIDTH-1:0]   tag;
        logic [WAY_WIDTH-1:0]   way;
    } fill_req_t;

    // miss queue entry
    typedef struct packed {
        logic [TXNID_WIDTH-1:0]  txnid;
        opcode_t                 opcode;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [TAG_WIDTH-1:0]    req_tag;
        logic [WAY_WIDTH-1:0]    way;
        logic                    hit;
        logic                    need_linefill;
        logic                    need_evict;
        logic [TAG_WIDTH-1:0]    evict_tag;
    } miss_entry_t;

endpackage

//--- hw/set_ram.sv
`timescale 1ns/1ps

module set_ram #(
    parameter type row_t = logic
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               rd_en,
    input  logic [vcache_pkg::INDEX_WIDTH-1:0] rd_addr,
    input  logic                               wr_en,
    input  logic [vcache_pkg::INDEX_WIDTH-1:0] wr_addr,
    input  row_t                               wr_data,
    output row_t                               rd_data
);

    row_t mem [2**vcache_pkg::INDEX_WIDTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**vcache_pkg::INDEX_WIDTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, a write to the same row is bypassed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= (wr_en && (wr_addr == rd_addr)) ? wr_data : mem[rd_addr];
        end
    end

endmodule

//--- hw/tag_req_stage.sv
`timescale 1ns/1ps

module tag_req_stage (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  tag_req_vld,
    input  vcache_pkg::tag_req_t  tag_req_pld,
    output logic                  tag_req_rdy,

    input  logic                  fill_load,
    input  vcache_pkg::fill_req_t fill_pld,
    output logic                  buf_vld,
    output vcache_pkg::fill_req_t buf_pld,

    output logic                  req_vld,
    output vcache_pkg::tag_req_t  req_pld,

    output logic                  tag_rd_en,
    output logic                  tag_wr_en
);

    logic req_fire;

    // ==============================
    // fill buffer
    // ==============================
    // one entry, drains into the tag RAM the cycle after it loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_vld <= 1'b0;
        end else begin
            buf_vld <= fill_load;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_load) begin
            buf_pld <= fill_pld;
        end
    end

    assign tag_req_rdy = ~buf_vld;  // hold off new lookups while the tag write drains

    // ==============================
    // tag RAM port control
    // ==============================
    assign req_fire  = tag_req_vld & tag_req_rdy;
    assign tag_rd_en = req_fire;    // set read at the accept edge
    assign tag_wr_en = buf_vld;

    // ==============================
    // request register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld <= 1'b0;
        end else begin
            req_vld <= req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pld <= tag_req_pld;     // lines up with the RAM read data
        end
    end

endmodule

//--- hw/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                tag_rd_en,
    input  logic                                tag_wr_en,
    input  logic [vcache_pkg::INDEX_WIDTH-1:0]  rd_index,

    input  logic                                req_vld,
    input  vcache_pkg::tag_req_t                req_pld,
    input  logic                                buf_vld,
    input  vcache_pkg::fill_req_t               buf_pld,

    output vcache_pkg::tag_row_t                eff_row,
    output vcache_pkg::dirty_row_t              dirty_row,
    output logic                                hit,
    output logic [vcache_pkg::WAY_NUM-1:0]      hit_way_oh,
    output logic [vcache_pkg::WAY_WIDTH-1:0]    victim_way
);

    vcache_pkg::tag_row_t             ram_row;
    vcache_pkg::tag_row_t             fill_row_q;
    vcache_pkg::tag_row_t             fill_row;
    vcache_pkg::dirty_row_t           dirty_wr_data;
    logic [vcache_pkg::WAY_NUM-1:0]   dest_oh;
    logic [vcache_pkg::WAY_WIDTH-1:0] victim_q;
    logic                             buf_same_set;
    logic                             is_write;
    logic                             dirty_wr_en;

    // ==============================
    // tag array
    // ==============================
    set_ram #(.row_t(vcache_pkg::tag_row_t)) u_tag_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (tag_rd_en),
        .rd_addr (rd_index),
        .wr_en   (tag_wr_en),
        .wr_addr (buf_pld.index),
        .wr_data (fill_row),
        .rd_data (ram_row)
    );

    // buffered tag is not in the RAM yet
    assign buf_same_set = buf_vld && (buf_pld.index == req_pld.addr.index);

    always_comb begin
        eff_row = ram_row;
        if (buf_same_set) begin
            eff_row.way[buf_pld.way].valid = 1'b1;
            eff_row.way[buf_pld.way].tag   = buf_pld.tag;
        end
    end

    always_comb begin
        for (int i = 0; i < vcache_pkg::WAY_NUM; i++) begin
            hit_way_oh[i] = eff_row.way[i].valid && (eff_row.way[i].tag == req_pld.addr.tag);
        end
    end

    assign hit = |hit_way_oh;

    // round robin, moves on misses only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= '0;
        end else if (req_vld && !hit) begin
            victim_q <= victim_q + 1'b1;
        end
    end

    assign victim_way = victim_q;

    // whole row goes back with the new way patched in
    always_ff @(posedge clk) begin
        if (req_vld && !hit) begin
            fill_row_q <= eff_row;
        end
    end

    always_comb begin
        fill_row = fill_row_q;
        fill_row.way[buf_pld.way].valid = 1'b1;
        fill_row.way[buf_pld.way].tag   = buf_pld.tag;
    end

    // ==============================
    // dirty array
    // ==============================
    always_comb begin
        for (int i = 0; i < vcache_pkg::WAY_NUM; i++) begin
            dest_oh[i] = hit ? hit_way_oh[i] : (victim_q == i[vcache_pkg::WAY_WIDTH-1:0]);
        end
    end

    assign is_write      = (req_pld.opcode == vcache_pkg::OP_WRITE);
    assign dirty_wr_en   = req_vld && (is_write || ((req_pld.opcode == vcache_pkg::OP_READ) && !hit));
    assign dirty_wr_data = is_write ? (dirty_row | dest_oh) : (dirty_row & ~dest_oh);

    set_ram #(.row_t(vcache_pkg::dirty_row_t)) u_dirty_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en   (tag_rd_en),
        .rd_addr (rd_index),
        .wr_en   (dirty_wr_en),
        .wr_addr (req_pld.addr.index),
        .wr_data (dirty_wr_data),
        .rd_data (dirty_row)
    );

endmodule

//--- hw/miss_entry_build.sv
`timescale 1ns/1ps

module miss_entry_build (
    input  logic                                req_vld,
    input  vcache_pkg::tag_req_t                req_pld,
    input  vcache_pkg::tag_row_t                eff_row,
    input  vcache_pkg::dirty_row_t              dirty_row,
    input  logic                                hit,
    input  logic [vcache_pkg::WAY_NUM-1:0]      hit_way_oh,
    input  logic [vcache_pkg::WAY_WIDTH-1:0]    victim_way,

    output logic                                miss_vld,
    output vcache_pkg::miss_entry_t             miss_pld,
    output logic                                fill_load,
    output vcache_pkg::fill_req_t               fill_pld
);

    logic [vcache_pkg::WAY_WIDTH-1:0] hit_way;
    logic [vcache_pkg::WAY_WIDTH-1:0] dest_way;
    logic                             victim_dirty;

    // one-hot to binary
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < vcache_pkg::WAY_NUM; i++) begin
            if (hit_way_oh[i]) begin
                hit_way = hit_way | i[vcache_pkg::WAY_WIDTH-1:0];
            end
        end
    end

    assign dest_way     = hit ? hit_way : victim_way;
    assign victim_dirty = eff_row.way[victim_way].valid && dirty_row[victim_way];

    // ==============================
    // miss queue entry
    // ==============================
    assign miss_vld                = req_vld;
    assign miss_pld.txnid          = req_pld.txnid;
    assign miss_pld.opcode         = req_pld.opcode;
    assign miss_pld.index          = req_pld.addr.index;
    assign miss_pld.offset         = req_pld.addr.offset;
    assign miss_pld.req_tag        = req_pld.addr.tag;
    assign miss_pld.way            = dest_way;
    assign miss_pld.hit            = hit;
    assign miss_pld.need_linefill  = !hit;
    assign miss_pld.need_evict     = !hit && victim_dirty;   // writeback of the old line
    assign miss_pld.evict_tag      = eff_row.way[dest_way].tag;

    // new tag for the victim way
    assign fill_load      = req_vld && !hit;
    assign fill_pld.index = req_pld.addr.index;
    assign fill_pld.tag   = req_pld.addr.tag;
    assign fill_pld.way   = victim_way;

endmodule

//--- hw/vcache_tag_ctrl.sv
`timescale 1ns/1ps

module vcache_tag_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tag_req_vld,
    input  vcache_pkg::tag_req_t    tag_req_pld,
    output logic                    tag_req_rdy,
    output logic                    miss_vld,
    output vcache_pkg::miss_entry_t miss_pld
);

    logic                             fill_load;
    vcache_pkg::fill_req_t            fill_pld;
    logic                             buf_vld;
    vcache_pkg::fill_req_t            buf_pld;
    logic                             req_vld;
    vcache_pkg::tag_req_t             req_pld;
    logic                             tag_rd_en;
    logic                             tag_wr_en;
    vcache_pkg::tag_row_t             eff_row;
    vcache_pkg::dirty_row_t           dirty_row;
    logic                             hit;
    logic [vcache_pkg::WAY_NUM-1:0]   hit_way_oh;
    logic [vcache_pkg::WAY_WIDTH-1:0] victim_way;

    tag_req_stage u_tag_req_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .tag_req_vld (tag_req_vld),
        .tag_req_pld (tag_req_pld),
        .tag_req_rdy (tag_req_rdy),
        .fill_load   (fill_load),
        .fill_pld    (fill_pld),
        .buf_vld     (buf_vld),
        .buf_pld     (buf_pld),
        .req_vld     (req_vld),
        .req_pld     (req_pld),
        .tag_rd_en   (tag_rd_en),
        .tag_wr_en   (tag_wr_en)
    );

    tag_lookup u_tag_lookup (
        .clk         (clk),
        .rst_n       (rst_n),
        .tag_rd_en   (tag_rd_en),
        .tag_wr_en   (tag_wr_en),
        .rd_index    (tag_req_pld.addr.index),
        .req_vld     (req_vld),
        .req_pld     (req_pld),
        .buf_vld     (buf_vld),
        .buf_pld     (buf_pld),
        .eff_row     (eff_row),
        .dirty_row   (dirty_row),
        .hit         (hit),
        .hit_way_oh  (hit_way_oh),
        .victim_way  (victim_way)
    );

    miss_entry_build u_miss_entry_build (
        .req_vld     (req_vld),
        .req_pld     (req_pld),
        .eff_row     (eff_row),
        .dirty_row   (dirty_row),
        .hit         (hit),
        .hit_way_oh  (hit_way_oh),
        .victim_way  (victim_way),
        .miss_vld    (miss_vld),
        .miss_pld    (miss_pld),
        .fill_load   (fill_load),
        .fill_pld    (fill_pld)
    );

endmodule

//--- test/vcache_tag_ctrl_sva.sv
`timescale 1ns/1ps

module vcache_tag_ctrl_sva (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           tag_req_vld,
    input logic                           tag_req_rdy,
    input logic                           miss_vld,
    input vcache_pkg::miss_entry_t        miss_pld,
    input logic [vcache_pkg::WAY_NUM-1:0] hit_way_oh
);

    // one result per accepted request, one cycle later
    a_result_latency: assert property (@(posedge clk) disable iff (!rst_n)
        miss_vld == $past(tag_req_vld && tag_req_rdy))
        else $error("miss_vld does not follow the request accept by one cycle");

    a_rdy_after_miss: assert property (@(posedge clk) disable iff (!rst_n)
        (miss_vld && !miss_pld.hit) |=> !tag_req_rdy)
        else $error("tag_req_rdy high in the cycle after a miss result");

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        miss_vld |-> $onehot0(hit_way_oh))
        else $error("more than one way hit");

endmodule

bind vcache_tag_ctrl vcache_tag_ctrl_sva i_vcache_tag_ctrl_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .tag_req_vld (tag_req_vld),
    .tag_req_rdy (tag_req_rdy),
    .miss_vld    (miss_vld),
    .miss_pld    (miss_pld),
    .hit_way_oh  (hit_way_oh)
);

//--- test/tb_vcache_tag_ctrl.sv
`timescale 1ns/1ps

module tb_vcache_tag_ctrl;

    localparam int DIRECTED_REQ   = 16;
    localparam int RANDOM_REQ     = 2000;
    localparam int TIMEOUT_CYCLES = 4 * (DIRECTED_REQ + RANDOM_REQ) + 50;
    localparam int SETS           = 2**vcache_pkg::INDEX_WIDTH;
    localparam int WAYS           = vcache_pkg::WAY_NUM;

    logic                    clk;
    logic                    rst_n;
    logic                    tag_req_vld;
    vcache_pkg::tag_req_t    tag_req_pld;
    logic                    tag_req_rdy;
    logic                    miss_vld;
    vcache_pkg::miss_entry_t miss_pld;

    // ==============================
    // reference model state
    // ==============================
    logic [vcache_pkg::TAG_WIDTH-1:0] tag_m   [SETS][WAYS];
    logic                             vld_m   [SETS][WAYS];
    logic                             dirty_m [SETS][WAYS];
    logic [vcache_pkg::WAY_WIDTH-1:0] victim_m;
    logic                             buf_m;     // fill buffer busy this cycle
    vcache_pkg::miss_entry_t          exp_q [$];

    int          entry_errs;
    int          rdy_errs;
    int          proto_errs;
    int          cycles;
    logic [31:0] rng;
    logic [7:0]  txn;

    vcache_tag_ctrl i_vcache_tag_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .tag_req_vld (tag_req_vld),
        .tag_req_pld (tag_req_pld),
        .tag_req_rdy (tag_req_rdy),
        .miss_vld    (miss_vld),
        .miss_pld    (miss_pld)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected entry and state update for one accepted request
    task automatic model_request(input vcache_pkg::tag_req_t req);
        vcache_pkg::miss_entry_t          e;
        logic [vcache_pkg::INDEX_WIDTH-1:0] idx;
        logic [vcache_pkg::WAY_WIDTH-1:0]   way;
        logic                               hit;
        idx = req.addr.index;
        hit = 1'b0;
        way = victim_m;
        for (int w = 0; w < WAYS; w++) begin
            if (vld_m[idx][w] && (tag_m[idx][w] == req.addr.tag)) begin
                hit = 1'b1;
                way = w[vcache_pkg::WAY_WIDTH-1:0];
            end
        end
        e.txnid         = req.txnid;
        e.opcode        = req.opcode;
        e.index         = idx;
        e.offset        = req.addr.offset;
        e.req_tag       = req.addr.tag;
        e.way           = way;
        e.hit           = hit;
        e.need_linefill = !hit;
        e.need_evict    = !hit && vld_m[idx][way] && dirty_m[idx][way];
        e.evict_tag     = tag_m[idx][way];
        if (req.opcode == vcache_pkg::OP_WRITE) begin
            dirty_m[idx][way] = 1'b1;
        end else if (!hit) begin
            dirty_m[idx][way] = 1'b0;  // clean linefill
        end
        if (!hit) begin
            tag_m[idx][way] = req.addr.tag;
            vld_m[idx][way] = 1'b1;
            victim_m        = victim_m + 2'd1;
        end
        exp_q.push_back(e);
    endtask

    task automatic check_entry(input vcache_pkg::miss_entry_t exp);
        if (miss_pld !== exp) begin
            entry_errs++;
            $display("FAILED %0t miss_pld expected %h actual %h", $time, exp, miss_pld);
        end
    endtask

    task automatic check_rdy(input logic exp);
        if (tag_req_rdy !== exp) begin
            rdy_errs++;
            $display("FAILED %0t tag_req_rdy expected %b actual %b", $time, exp, tag_req_rdy);
        end
    endtask

    // ==============================
    // monitor at mid cycle
    // ==============================
    always @(negedge clk) begin : monitor
        vcache_pkg::miss_entry_t e;
        logic                    next_buf;
        if (rst_n) begin
            check_rdy(!buf_m);
            next_buf = 1'b0;
            if (miss_vld) begin
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("miss_vld high at %0t with no request accepted before", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_entry(e);
                    next_buf = !e.hit;
                end
            end else if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                proto_errs++;
                $display("no result at %0t for accepted txnid %h", $time, e.txnid);
                next_buf = !e.hit;
            end
            if (tag_req_vld && !buf_m) begin
                model_request(tag_req_pld);
            end
            buf_m = next_buf;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, stimulus did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // holds the request until the DUT takes it
    task automatic send(input vcache_pkg::opcode_t op, input logic [11:0] tag,
                        input logic [5:0] idx, input logic [5:0] off);
        tag_req_vld              = 1'b1;
        tag_req_pld.txnid        = txn;
        tag_req_pld.opcode       = op;
        tag_req_pld.addr.tag     = tag;
        tag_req_pld.addr.index   = idx;
        tag_req_pld.addr.offset  = off;
        txn++;
        @(negedge clk);
        while (!tag_req_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        tag_req_vld = 1'b0;
    endtask

    task automatic idle(input int n);
        tag_req_vld = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        tag_req_vld = 1'b0;
        tag_req_pld = '0;
        rng         = 32'h5e0;
        txn         = '0;
        buf_m       = 1'b0;
        victim_m    = '0;
        entry_errs  = 0;
        rdy_errs    = 0;
        proto_errs  = 0;
        cycles      = 0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                tag_m[s][w]   = '0;
                vld_m[s][w]   = 1'b0;
                dirty_m[s][w] = 1'b0;
            end
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);

        // cold miss then a hit through the fill buffer overlay
        send(vcache_pkg::OP_READ, 12'h111, 6'd1, 6'd0);
        send(vcache_pkg::OP_READ, 12'h111, 6'd1, 6'd4);
        for (int i = 0; i < 3; i++) begin
            send(vcache_pkg::OP_READ, 12'h300 + 12'(i), 6'd3, 6'd0);  // pointer back to way 0
        end
        // ways 0..3 then 0 again where the last one evicts 12'h201
        for (int i = 0; i < 5; i++) begin
            send(vcache_pkg::OP_READ, 12'h201 + 12'(i), 6'd2, 6'd0);
        end
        send(vcache_pkg::OP_WRITE, 12'h202, 6'd2, 6'd8);   // dirty way 1
        send(vcache_pkg::OP_READ, 12'h206, 6'd2, 6'd0);    // dirty eviction
        for (int i = 0; i < 3; i++) begin
            send(vcache_pkg::OP_READ, 12'h207 + 12'(i), 6'd2, 6'd0);
        end
        send(vcache_pkg::OP_READ, 12'h20a, 6'd2, 6'd0);    // way 1 again but clean
        idle(2);

        // ==============================
        // random traffic
        // ==============================
        for (int n = 0; n < RANDOM_REQ; n++) begin
            rng = xorshift(rng);
            if (rng[31:29] == 3'd0) begin
                idle(1);    // occasional gap
            end
            send(rng[28] ? vcache_pkg::OP_WRITE : vcache_pkg::OP_READ,
                 {9'h080, rng[2:0]}, {2'b10, rng[4:3], 2'b00}, rng[10:5]);
        end
        idle(4);
        if (exp_q.size() != 0) begin
            proto_errs++;
            $display("%0d expected results never appeared", exp_q.size());
        end

        $display("errors: entry %0d, rdy %0d, protocol %0d", entry_errs, rdy_errs, proto_errs);
        if (entry_errs + rdy_errs + proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/vcache_pkg.sv
hw/set_ram.sv
hw/tag_req_stage.sv
hw/tag_lookup.sv
hw/miss_entry_build.sv
hw/vcache_tag_ctrl.sv
test/vcache_tag_ctrl_sva.sv
test/tb_vcache_tag_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the tag controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vcache_tag_ctrl -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
